// File: all.f
+incdir+src
src/bno_shtp_pkg.sv
src/bno_ctrl_pkg.sv
src/bno_seq_ctrl.sv
src/spi_byte_sequencer.sv
src/shtp_cmd_rom.sv
src/shtp_rx_parser.sv
src/bno085_hub.sv
tb/bno085_hub_checker.sv
tb/tb_bno085_hub.sv

// File: Bender.yml
package:
  name: bno085_hub

sources:
  - include_dirs:
      - src
    files:
      - src/bno_shtp_pkg.sv
      - src/bno_ctrl_pkg.sv
      - src/bno_seq_ctrl.sv
      - src/spi_byte_sequencer.sv
      - src/shtp_cmd_rom.sv
      - src/shtp_rx_parser.sv
      - src/bno085_hub.sv
  - target: test
    files:
      - tb/bno085_hub_checker.sv
      - tb/tb_bno085_hub.sv

// File: tb/tb_bno085_hub.sv
`timescale 1ns/1ps
`default_nettype none

module tb_bno085_hub
    import bno_shtp_pkg::*;
();

    localparam int reset_wait  = 20;
    localparam int wake_hold   = 4;
    localparam int int_timeout = 30;
    localparam int cmd_gap     = 6;

    localparam int n_pkts      = 7;
    localparam int init_cycles = 1500;   // Fault pass plus three commands
    localparam int pkt_cycles  = 200;    // Worst case for a 16-byte packet
    localparam int watchdog_ns = (init_cycles + n_pkts * pkt_cycles) * 10;

    typedef struct packed {
        logic [7:0]  chan;
        logic [7:0]  rid;
        logic [7:0]  len;        // SHTP length field including the header
        logic [15:0] ax;
        logic [15:0] ay;
        logic [15:0] az;
        logic [15:0] aw;
        logic        quat_exp;
        logic        gyro_exp;
    } pkt_entry_t;

    logic       clk;
    logic       rst_n;
    logic       int_n;
    logic       spi_done;
    shtp_byte_t spi_rx_data;
    logic       spi_start;
    shtp_byte_t spi_tx_data;
    logic       cs_n;
    logic       ps0_wake;
    logic       initialized;
    logic       error;
    logic       quat_valid;
    quat_vec_t  quat;
    logic       gyro_valid;
    gyro_vec_t  gyro;

    pkt_entry_t pkt_table [n_pkts];
    logic [7:0] pkt [32];              // Bytes the sensor serves
    logic [7:0] tx_log [$];            // Bytes the host sent
    logic [31:0] lfsr = 32'hb65c38d7;
    logic [1:0] dly_bits;
    logic [1:0] eng_wait;
    logic       eng_busy = 1'b0;
    int         rx_pos = 0;
    int         quat_pulses = 0;
    int         gyro_pulses = 0;
    int         errors;
    int         cycles;
    int         pos;
    int         total;
    quat_vec_t  exp_quat;
    gyro_vec_t  exp_gyro;

    bno085_hub #(
        .reset_wait  (reset_wait),
        .wake_hold   (wake_hold),
        .int_timeout (int_timeout),
        .cmd_gap     (cmd_gap)
    ) i_bno085_hub (
        .clk, .rst_n, .int_n, .spi_done, .spi_rx_data, .spi_start, .spi_tx_data,
        .cs_n, .ps0_wake, .initialized, .error, .quat_valid, .quat, .gyro_valid, .gyro
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // Command image as the SHTP layout defines it
    function automatic logic [7:0] expected_cmd_byte(input int step, input int idx);
        logic [31:0] interval;
        interval = 32'd20000;
        case (idx)
            0: return (step == 0) ? 8'd5 : 8'd17;
            2: return 8'h02;
            3: return step[7:0];
            4: return (step == 0) ? 8'hf9 : 8'hfd;
            5: return (step == 1) ? 8'h05 : ((step == 2) ? 8'h02 : 8'h00);
            9, 10, 11, 12: return (step == 0) ? 8'h00 : interval[(idx - 9) * 8 +: 8];
            default: return 8'h00;
        endcase
    endfunction

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] exp);
        $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp);
        errors++;
    endtask

    task automatic wait_signal(input string name, input logic level, input int limit);
        int   n;
        logic v;
        n = 0;
        v = ~level;
        while (v !== level && n < limit) begin
            @(negedge clk);
            n++;
            case (name)
                "cs_n":     v = cs_n;
                "ps0_wake": v = ps0_wake;
                "error":    v = error;
                default:    v = initialized;
            endcase
        end
        if (v !== level) begin
            $display("Timed out after %0d cycles waiting for %s to become %0b",
                     limit, name, level);
            errors++;
        end
    endtask

    // SPI engine that raises done 1 to 4 cycles after each start
    always @(posedge clk) begin
        spi_done <= 1'b0;
        if (cs_n) rx_pos <= 0;
        if (spi_start) begin
            tx_log.push_back(spi_tx_data);
            lfsr = lfsr_next(lfsr);
            dly_bits[0] = lfsr[0];
            lfsr = lfsr_next(lfsr);
            dly_bits[1] = lfsr[0];
            eng_wait <= dly_bits;
            eng_busy <= 1'b1;
        end else if (eng_busy) begin
            if (eng_wait == 2'd0) begin
                spi_done    <= 1'b1;
                spi_rx_data <= pkt[rx_pos];
                rx_pos      <= rx_pos + 1;
                eng_busy    <= 1'b0;
            end else begin
                eng_wait <= eng_wait - 1'b1;
            end
        end
    end

    always @(posedge clk) begin
        if (quat_valid) quat_pulses <= quat_pulses + 1;
        if (gyro_valid) gyro_pulses <= gyro_pulses + 1;
    end

    task automatic load_packet(input pkt_entry_t e, input int seq);
        for (int i = 0; i < 32; i++) pkt[i] = 8'h00;
        pkt[0]  = e.len;
        pkt[2]  = e.chan;
        pkt[3]  = seq[7:0];
        pkt[4]  = e.rid;
        pkt[5]  = 8'hc3;               // Sequence, status, delay bytes
        pkt[6]  = 8'h3c;
        pkt[7]  = 8'ha5;
        pkt[8]  = e.ax[7:0];
        pkt[9]  = e.ax[15:8];
        pkt[10] = e.ay[7:0];
        pkt[11] = e.ay[15:8];
        pkt[12] = e.az[7:0];
        pkt[13] = e.az[15:8];
        pkt[14] = e.aw[7:0];
        pkt[15] = e.aw[15:8];
    endtask

    // Sensor side of one wake and command transfer
    task automatic answer_wake();
        wait_signal("ps0_wake", 1'b0, init_cycles);
        @(posedge clk);
        int_n <= 1'b0;
        wait_signal("cs_n", 1'b0, pkt_cycles);
        @(posedge clk);
        int_n <= 1'b1;
        wait_signal("cs_n", 1'b1, pkt_cycles);
    endtask

    task automatic serve_packet(input pkt_entry_t e, input int seq);
        int q0;
        int g0;
        int t0;
        int n_bytes;
        load_packet(e, seq);
        q0 = quat_pulses;
        g0 = gyro_pulses;
        t0 = tx_log.size();
        n_bytes = (e.len > 8'd4) ? int'(e.len) : 4;
        @(posedge clk);
        int_n <= 1'b0;                 // Packet pending
        wait_signal("cs_n", 1'b0, pkt_cycles);
        @(posedge clk);
        int_n <= 1'b1;
        wait_signal("cs_n", 1'b1, pkt_cycles);
        repeat (3) @(negedge clk);
        if (e.quat_exp) begin
            exp_quat.x = e.ax;
            exp_quat.y = e.ay;
            exp_quat.z = e.az;
            exp_quat.w = e.aw;
        end
        if (e.gyro_exp) begin
            exp_gyro.x = e.ax;
            exp_gyro.y = e.ay;
            exp_gyro.z = e.az;
        end
        if (quat_pulses - q0 != int'(e.quat_exp))
            report_mismatch("quat_valid pulses", quat_pulses - q0, e.quat_exp);
        if (gyro_pulses - g0 != int'(e.gyro_exp))
            report_mismatch("gyro_valid pulses", gyro_pulses - g0, e.gyro_exp);
        if (quat !== exp_quat) report_mismatch("quat", quat, exp_quat);
        if (gyro !== exp_gyro) report_mismatch("gyro", gyro, exp_gyro);
        if (cs_n !== 1'b1) report_mismatch("cs_n", cs_n, 1'b1);
        if (tx_log.size() - t0 != n_bytes)
            report_mismatch("spi byte count", tx_log.size() - t0, n_bytes);
        // Reads clock out zeros
        for (int i = t0; i < tx_log.size(); i++) begin
            if (tx_log[i] !== 8'h00)
                report_mismatch("spi_tx_data", tx_log[i], 8'h00);
        end
    endtask

    initial begin
        #(watchdog_ns);
        $display("Watchdog expired at %0d ns, the run stalled", watchdog_ns);
        $display("Test failed");
        $finish;
    end

    initial begin
        errors   = 0;
        exp_quat = '0;
        exp_gyro = '0;
        pkt_table[0] = '{8'h03, 8'h05, 8'd16, 16'h1234, 16'habcd, 16'h8001, 16'h7fff, 1'b1, 1'b0};
        pkt_table[1] = '{8'h05, 8'h02, 8'd14, 16'h0102, 16'hfedc, 16'h55aa, 16'h0000, 1'b0, 1'b1};
        pkt_table[2] = '{8'h02, 8'h05, 8'd16, 16'h1111, 16'h2222, 16'h3333, 16'h4444, 1'b0, 1'b0};
        pkt_table[3] = '{8'h03, 8'h01, 8'd16, 16'h5555, 16'h6666, 16'h7777, 16'h8888, 1'b0, 1'b0};
        pkt_table[4] = '{8'h03, 8'h05, 8'd4,  16'h9999, 16'haaaa, 16'hbbbb, 16'hcccc, 1'b0, 1'b0};
        pkt_table[5] = '{8'h05, 8'h05, 8'd16, 16'h0f0e, 16'h0d0c, 16'h0b0a, 16'h0908, 1'b1, 1'b0};
        pkt_table[6] = '{8'h03, 8'h02, 8'd14, 16'h8765, 16'h4321, 16'h0ff0, 16'h0000, 1'b0, 1'b1};
        rst_n       = 1'b0;
        int_n       = 1'b1;
        spi_done    = 1'b0;
        spi_rx_data = 8'h00;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;

        // Idle levels until the power-up wait ends
        repeat (10) begin
            @(negedge clk);
            if ({cs_n, ps0_wake, spi_start, initialized, error} !== 5'b11000)
                report_mismatch("cs_n,ps0_wake,spi_start,initialized,error",
                                {cs_n, ps0_wake, spi_start, initialized, error}, 5'b11000);
        end

        // No INT at all, so the first wait must time out
        wait_signal("error", 1'b1, init_cycles);
        if (ps0_wake !== 1'b1) report_mismatch("ps0_wake", ps0_wake, 1'b1);
        cycles = 0;
        while (ps0_wake !== 1'b0 && cycles < init_cycles) begin
            @(negedge clk);
            cycles++;
        end
        if (cycles != reset_wait + 1) report_mismatch("ps0_wake delay", cycles, reset_wait + 1);

        repeat (3) answer_wake();
        wait_signal("initialized", 1'b1, init_cycles);
        if (tx_log.size() != 39) begin
            $display("Host sent %0d command bytes instead of 39", tx_log.size());
            errors++;
        end else begin
            pos = 0;
            for (int s = 0; s < 3; s++) begin
                for (int i = 0; i < ((s == 0) ? 5 : 17); i++) begin
                    if (tx_log[pos] !== expected_cmd_byte(s, i))
                        report_mismatch("spi_tx_data", tx_log[pos], expected_cmd_byte(s, i));
                    pos++;
                end
            end
        end

        for (int i = 0; i < n_pkts; i++) serve_packet(pkt_table[i], i);

        if (error !== 1'b1) report_mismatch("error", error, 1'b1);     // Sticky
        if (initialized !== 1'b1) report_mismatch("initialized", initialized, 1'b1);

        total = errors + int'(i_bno085_hub.i_checker.assert_errors);
        $display("Checks done: %0d errors, %0d assertion failures", errors,
                 i_bno085_hub.i_checker.assert_errors);
        if (total == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb/bno085_hub_checker.sv
`timescale 1ns/1ps
`default_nettype none

module bno085_hub_checker (
    input logic clk,
    input logic rst_n,
    input logic spi_start,
    input logic spi_done,
    input logic cs_n,
    input logic quat_valid,
    input logic gyro_valid
);

    int unsigned assert_errors = 0;   // Failure count, summed by the testbench

    // Bytes only move while the hub is selected
    a_start_selected: assert property (@(posedge clk) disable iff (!rst_n)
        spi_start |-> !cs_n)
        else begin
            $error("spi_start issued while cs_n is high");
            assert_errors++;
        end

    // Next byte starts no earlier than the cycle after done
    a_start_not_on_done: assert property (@(posedge clk) disable iff (!rst_n)
        !(spi_start && spi_done))
        else begin
            $error("spi_start and spi_done high in the same cycle");
            assert_errors++;
        end

    a_one_report: assert property (@(posedge clk) disable iff (!rst_n)
        !(quat_valid && gyro_valid))
        else begin
            $error("quat_valid and gyro_valid high together");
            assert_errors++;
        end

endmodule

bind bno085_hub bno085_hub_checker i_checker (
    .clk        (clk),
    .rst_n      (rst_n),
    .spi_start  (spi_start),
    .spi_done   (spi_done),
    .cs_n       (cs_n),
    .quat_valid (quat_valid),
    .gyro_valid (gyro_valid)
);

`default_nettype wire

// File: src/bno085_hub.sv
`timescale 1ns/1ps
`default_nettype none

`include "bno_consts.svh"

module bno085_hub
    import bno_shtp_pkg::*;
    import bno_ctrl_pkg::*;
#(
    parameter int unsigned reset_wait  = `BNO_RESET_WAIT,
    parameter int unsigned wake_hold   = `BNO_WAKE_HOLD,
    parameter int unsigned int_timeout = `BNO_INT_TIMEOUT,
    parameter int unsigned cmd_gap     = `BNO_CMD_GAP
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       int_n,
    input  logic       spi_done,
    input  shtp_byte_t spi_rx_data,
    output logic       spi_start,
    output shtp_byte_t spi_tx_data,
    output logic       cs_n,
    output logic       ps0_wake,
    output logic       initialized,
    output logic       error,
    output logic       quat_valid,
    output quat_vec_t  quat,
    output logic       gyro_valid,
    output gyro_vec_t  gyro
);

    logic       run_go;
    byte_idx_t  run_len;
    logic       run_tx_from_rom;
    byte_idx_t  byte_idx;
    logic       run_end;
    shtp_byte_t rom_byte;
    byte_idx_t  cmd_len;
    cmd_step_t  step;
    rx_phase_t  rx_phase;
    shtp_len_t  payload_len;
    logic       hdr_ok;

    bno_seq_ctrl #(
        .reset_wait  (reset_wait),
        .wake_hold   (wake_hold),
        .int_timeout (int_timeout),
        .cmd_gap     (cmd_gap)
    ) i_seq_ctrl (
        .clk, .rst_n, .int_n, .run_end, .hdr_ok, .payload_len, .cmd_len,
        .run_go, .run_len, .run_tx_from_rom, .step, .rx_phase,
        .cs_n, .ps0_wake, .initialized, .error
    );

    spi_byte_sequencer i_byte_seq (
        .clk, .rst_n, .run_go, .run_len, .run_tx_from_rom, .rom_byte,
        .spi_done, .spi_start, .spi_tx_data, .byte_idx, .run_end
    );

    shtp_cmd_rom i_cmd_rom (
        .step, .byte_idx, .rom_byte, .cmd_len
    );

    shtp_rx_parser i_rx_parser (
        .clk, .rst_n, .spi_done, .spi_rx_data, .byte_idx, .rx_phase,
        .payload_len, .hdr_ok, .quat_valid, .quat, .gyro_valid, .gyro
    );

endmodule

`default_nettype wire

// File: src/shtp_rx_parser.sv
`timescale 1ns/1ps
`default_nettype none

`include "bno_consts.svh"

module shtp_rx_parser
    import bno_shtp_pkg::*;
    import bno_ctrl_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       spi_done,
    input  shtp_byte_t spi_rx_data,
    input  byte_idx_t  byte_idx,
    input  rx_phase_t  rx_phase,
    output shtp_len_t  payload_len,
    output logic       hdr_ok,
    output logic       quat_valid,
    output quat_vec_t  quat,
    output logic       gyro_valid,
    output gyro_vec_t  gyro
);

    shtp_len_t     pkt_len;
    shtp_channel_t chan;
    report_id_t    rid;
    shtp_byte_t    lsb;
    axis_t         axis_val;
    logic          chan_ok;
    logic          is_rot;
    logic          is_gyro;

    assign payload_len = pkt_len - shtp_len_t'(`BNO_HDR_BYTES);
    assign hdr_ok      = pkt_len > shtp_len_t'(`BNO_HDR_BYTES);   // Bit 15 already dropped
    assign chan_ok     = (chan == `BNO_CH_REPORTS) || (chan == `BNO_CH_GYRO_RV);
    assign is_rot      = (rid == `BNO_RID_ROT_VEC);
    assign is_gyro     = (rid == `BNO_RID_GYRO);
    assign axis_val    = {spi_rx_data, lsb};      // High byte arrives second

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pkt_len <= '0;
            chan    <= '0;
        end else if (spi_done && rx_phase == HEADER) begin
            case (byte_idx)
                8'd0: pkt_len[7:0]  <= spi_rx_data;
                8'd1: pkt_len[15:8] <= {1'b0, spi_rx_data[6:0]};  // Continuation bit off
                8'd2: chan          <= spi_rx_data;
                default: ;
            endcase
        end
    end

    // Report ID and low byte holding
    always_ff @(posedge clk) begin
        if (spi_done && rx_phase == PAYLOAD && chan_ok) begin
            if (byte_idx == 8'd0) begin
                rid <= spi_rx_data;
            end
            if (byte_idx >= 8'd4 && !byte_idx[0]) begin
                lsb <= spi_rx_data;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            quat       <= '0;
            gyro       <= '0;
            quat_valid <= 1'b0;
            gyro_valid <= 1'b0;
        end else begin
            quat_valid <= 1'b0;
            gyro_valid <= 1'b0;
            // Odd bytes 5..11 complete x, y, z, w
            if (spi_done && rx_phase == PAYLOAD && chan_ok && byte_idx[0]
                    && byte_idx >= 8'd5 && byte_idx <= 8'd11) begin
                case (byte_idx[3:1])
                    3'd2: begin
                        if (is_rot)  quat.x <= axis_val;
                        if (is_gyro) gyro.x <= axis_val;
                    end
                    3'd3: begin
                        if (is_rot)  quat.y <= axis_val;
                        if (is_gyro) gyro.y <= axis_val;
                    end
                    3'd4: begin
                        if (is_rot) quat.z <= axis_val;
                        if (is_gyro) begin
                            gyro.z     <= axis_val;
                            gyro_valid <= 1'b1;     // Gyro report ends at z
                        end
                    end
                    3'd5: begin
                        if (is_rot) begin
                            quat.w     <= axis_val;
                            quat_valid <= 1'b1;
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// File: src/shtp_cmd_rom.sv
`timescale 1ns/1ps
`default_nettype none

`include "bno_consts.svh"

module shtp_cmd_rom
    import bno_shtp_pkg::*;
    import bno_ctrl_pkg::*;
(
    input  cmd_step_t  step,
    input  byte_idx_t  byte_idx,
    output shtp_byte_t rom_byte,
    output byte_idx_t  cmd_len
);

    localparam shtp_byte_t rid_prod_id_req = 8'hf9;
    localparam shtp_byte_t rid_set_feature = 8'hfd;
    localparam logic [31:0] interval       = `BNO_REPORT_INTERVAL;

    report_id_t feat_rid;
    logic       is_feat;

    assign is_feat  = (step != cmd_step_t'(0));
    assign feat_rid = (step == cmd_step_t'(1)) ? `BNO_RID_ROT_VEC : `BNO_RID_GYRO;
    assign cmd_len  = is_feat ? byte_idx_t'(`BNO_CMD_FEAT_LEN) : byte_idx_t'(`BNO_CMD_PROD_LEN);

    always_comb begin
        rom_byte = 8'h00;
        case (byte_idx)
            8'd0: rom_byte = cmd_len;                 // Length LSB, MSB stays zero
            8'd2: rom_byte = 8'h02;                   // Control channel
            8'd3: rom_byte = {6'd0, step};            // Sequence number
            8'd4: rom_byte = is_feat ? rid_set_feature : rid_prod_id_req;
            8'd5: if (is_feat) rom_byte = feat_rid;
            // Report interval, little-endian
            8'd9:  if (is_feat) rom_byte = interval[7:0];
            8'd10: if (is_feat) rom_byte = interval[15:8];
            8'd11: if (is_feat) rom_byte = interval[23:16];
            8'd12: if (is_feat) rom_byte = interval[31:24];
            default: rom_byte = 8'h00;
        endcase
    end

endmodule

`default_nettype wire

// File: src/spi_byte_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module spi_byte_sequencer
    import bno_shtp_pkg::*;
    import bno_ctrl_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       run_go,
    input  byte_idx_t  run_len,
    input  logic       run_tx_from_rom,
    input  shtp_byte_t rom_byte,
    input  logic       spi_done,
    output logic       spi_start,
    output shtp_byte_t spi_tx_data,
    output byte_idx_t  byte_idx,
    output logic       run_end
);

    logic      busy;
    byte_idx_t last_idx;

    // Reads clock out zeros
    assign spi_tx_data = run_tx_from_rom ? rom_byte : 8'h00;
    assign run_end     = busy && spi_done && (byte_idx == last_idx);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy      <= 1'b0;
            spi_start <= 1'b0;
            byte_idx  <= '0;
            last_idx  <= '0;
        end else begin
            spi_start <= 1'b0;
            if (run_go) begin
                busy      <= 1'b1;
                byte_idx  <= '0;
                last_idx  <= run_len - 1'b1;
                spi_start <= 1'b1;
            end else if (busy && spi_done) begin
                if (run_end) begin
                    busy <= 1'b0;
                end else begin
                    byte_idx  <= byte_idx + 1'b1;
                    spi_start <= 1'b1;    // Next byte right after done
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: src/bno_seq_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "bno_consts.svh"

module bno_seq_ctrl
    import bno_shtp_pkg::*;
    import bno_ctrl_pkg::*;
#(
    parameter int unsigned reset_wait  = `BNO_RESET_WAIT,
    parameter int unsigned wake_hold   = `BNO_WAKE_HOLD,
    parameter int unsigned int_timeout = `BNO_INT_TIMEOUT,
    parameter int unsigned cmd_gap     = `BNO_CMD_GAP
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       int_n,
    input  logic       run_end,
    input  logic       hdr_ok,
    input  shtp_len_t  payload_len,
    input  byte_idx_t  cmd_len,
    output logic       run_go,
    output byte_idx_t  run_len,
    output logic       run_tx_from_rom,
    output cmd_step_t  step,
    output rx_phase_t  rx_phase,
    output logic       cs_n,
    output logic       ps0_wake,
    output logic       initialized,
    output logic       error
);

    // One counter serves every delay and is sized for the longest
    localparam int unsigned max_ab = (reset_wait > int_timeout) ? reset_wait : int_timeout;
    localparam int unsigned max_cd = (wake_hold > cmd_gap) ? wake_hold : cmd_gap;
    localparam int unsigned cnt_w  = $clog2(((max_ab > max_cd) ? max_ab : max_cd) + 1);

    typedef logic [cnt_w-1:0] dly_cnt_t;

    ctrl_state_t state;
    dly_cnt_t    dly;
    logic        int_sync;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            int_sync <= 1'b1;
        end else begin
            int_sync <= int_n;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state           <= POWER_UP;
            dly             <= '0;
            step            <= '0;
            cs_n            <= 1'b1;
            ps0_wake        <= 1'b1;
            initialized     <= 1'b0;
            error           <= 1'b0;
            run_go          <= 1'b0;
            run_len         <= '0;
            run_tx_from_rom <= 1'b0;
            rx_phase        <= HEADER;
        end else begin
            run_go <= 1'b0;
            case (state)
                POWER_UP: begin
                    if (dly == dly_cnt_t'(reset_wait)) begin
                        dly      <= '0;
                        step     <= '0;
                        ps0_wake <= 1'b0;      // Wake the hub for the first command
                        state    <= WAKE;
                    end else begin
                        dly <= dly + 1'b1;
                    end
                end
                WAKE: begin
                    if (dly == dly_cnt_t'(wake_hold)) begin
                        dly   <= '0;
                        state <= WAIT_INT;
                    end else begin
                        dly <= dly + 1'b1;
                    end
                end
                WAIT_INT: begin
                    if (!int_sync) begin
                        cs_n            <= 1'b0;
                        ps0_wake        <= 1'b1;   // Released once selected
                        run_go          <= 1'b1;
                        run_len         <= cmd_len;
                        run_tx_from_rom <= 1'b1;
                        state           <= CMD_SEND;
                    end else if (dly == dly_cnt_t'(int_timeout)) begin
                        state <= FAULT;
                    end else begin
                        dly <= dly + 1'b1;
                    end
                end
                CMD_SEND: begin
                    if (run_end) begin
                        cs_n  <= 1'b1;
                        dly   <= '0;
                        state <= CMD_GAP;
                    end
                end
                CMD_GAP: begin
                    if (dly == dly_cnt_t'(cmd_gap)) begin
                        dly <= '0;
                        if (step == cmd_step_t'(2)) begin
                            initialized <= 1'b1;
                            state       <= IDLE;
                        end else begin
                            step     <= step + 1'b1;
                            ps0_wake <= 1'b0;
                            state    <= WAKE;
                        end
                    end else begin
                        dly <= dly + 1'b1;
                    end
                end
                IDLE: begin
                    // Hub has a packet for us
                    if (!int_sync) begin
                        cs_n            <= 1'b0;
                        run_go          <= 1'b1;
                        run_len         <= byte_idx_t'(`BNO_HDR_BYTES);
                        run_tx_from_rom <= 1'b0;
                        rx_phase        <= HEADER;
                        state           <= HDR_READ;
                    end
                end
                HDR_READ: begin
                    if (run_end) begin
                        if (hdr_ok) begin
                            run_go   <= 1'b1;
                            // Longer payloads are cut at 255 bytes
                            run_len  <= (payload_len > 16'd255) ? 8'hff : payload_len[7:0];
                            rx_phase <= PAYLOAD;
                            state    <= PAY_READ;
                        end else begin
                            cs_n  <= 1'b1;
                            state <= IDLE;
                        end
                    end
                end
                PAY_READ: begin
                    if (run_end) begin
                        cs_n  <= 1'b1;
                        state <= IDLE;
                    end
                end
                FAULT: begin
                    error    <= 1'b1;    // Sticky until reset
                    ps0_wake <= 1'b1;
                    dly      <= '0;
                    state    <= POWER_UP;
                end
                default: state <= POWER_UP;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: src/bno_ctrl_pkg.sv
`default_nettype none

// Controller side types
package bno_ctrl_pkg;

    typedef enum logic [3:0] {
        POWER_UP,
        WAKE,
        WAIT_INT,
        CMD_SEND,
        CMD_GAP,
        IDLE,
        HDR_READ,
        PAY_READ,
        FAULT
    } ctrl_state_t;

    typedef logic [1:0] cmd_step_t;    // Init command number
    typedef logic [7:0] byte_idx_t;    // Byte position in a run

    typedef enum logic {HEADER, PAYLOAD} rx_phase_t;

endpackage

`default_nettype wire

// File: src/bno_shtp_pkg.sv
`default_nettype none

// SHTP transport and sensor data types
package bno_shtp_pkg;

    typedef logic [7:0]  shtp_byte_t;     // One byte on the SPI wire
    typedef logic [15:0] shtp_len_t;      // Packet length, header included
    typedef logic [7:0]  shtp_channel_t;
    typedef logic [7:0]  report_id_t;

    // Q-point fixed value, scale depends on the report
    typedef logic signed [15:0] axis_t;

    // Rotation vector quaternion
    typedef struct packed {
        axis_t w;
        axis_t x;
        axis_t y;
        axis_t z;
    } quat_vec_t;

    typedef struct packed {
        axis_t x;
        axis_t y;
        axis_t z;
    } gyro_vec_t;

endpackage

`default_nettype wire

// File: src/bno_consts.svh
`ifndef BNO_CONSTS_SVH
`define BNO_CONSTS_SVH

// Default delays in clock cycles, tuned for a 30 MHz clock
`define BNO_RESET_WAIT   300000
`define BNO_WAKE_HOLD    450
`define BNO_INT_TIMEOUT  150000
`define BNO_CMD_GAP      30000

`define BNO_HDR_BYTES    4        // Length LSB, length MSB, channel, sequence

// Input report channels
`define BNO_CH_REPORTS   8'h03
`define BNO_CH_GYRO_RV   8'h05

`define BNO_RID_ROT_VEC  8'h05
`define BNO_RID_GYRO     8'h02

`define BNO_CMD_PROD_LEN 5
`define BNO_CMD_FEAT_LEN 17
`define BNO_REPORT_INTERVAL 32'd20000   // Microseconds, 50 Hz

`endif
